//--- project.f
rtl/cgra_pkg.sv
rtl/cgra_conf_loader.sv
rtl/cgra_conf_reader_pe.sv
rtl/cgra_pe_conf_store.sv
rtl/cgra_net_conf_reader.sv
rtl/cgra_conf_readback.sv
rtl/cgra_conf_top.sv
tests/cgra_conf_checker.sv
tests/tb_cgra_conf.sv

//--- Makefile
TOP := tb_cgra_conf

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_cgra_conf.sv
module tb_cgra_conf
  import cgra_pkg::*;
();

  localparam int TIMEOUT    = 200;
  localparam int NUM_ROUNDS = 400;

  logic             clk;
  logic             rst;
  logic             conf_valid;
  conf_word_t       conf_word;
  logic             conf_ready;
  logic             rb_valid;
  rb_req_t          rb_req;
  logic             rb_ready;
  logic             rsp_valid;
  logic             rsp_ready;
  logic [RB_DW-1:0] rsp_data;
  logic [RB_DW-1:0] rb_exp;
  int               err_count;
  int               rsp_count;
  int               reads_issued;
  int               tb_errors;
  logic             timed_out;
  logic [31:0]      rng_state;

  // Mirror of every PE store and the network tables
  logic [INST_W-1:0] m_inst [NUM_PE][INST_DEPTH];
  logic [15:0]       m_const [NUM_PE][CONST_DEPTH];
  logic [7:0]        m_pc_max [NUM_PE];
  logic [7:0]        m_pc_loop [NUM_PE];
  logic [7:0]        m_ignore [NUM_PE];
  logic [2:0]        m_thread [NUM_PE];
  logic [7:0]        m_net_pc_max;
  logic [7:0]        m_net_pc_loop;
  logic [15:0]       m_sw [SW_DEPTH];

  cgra_conf_top u_cgra_conf_top (
    .clk        (clk),
    .rst        (rst),
    .conf_valid (conf_valid),
    .conf_word  (conf_word),
    .conf_ready (conf_ready),
    .rb_valid   (rb_valid),
    .rb_req     (rb_req),
    .rb_ready   (rb_ready),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_data   (rsp_data)
  );

  cgra_conf_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .conf_valid (conf_valid),
    .conf_ready (conf_ready),
    .rb_valid   (rb_valid),
    .rb_ready   (rb_ready),
    .rb_req     (rb_req),
    .rb_exp     (rb_exp),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_data   (rsp_data),
    .err_count  (err_count),
    .rsp_count  (rsp_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ################################################
  // Random source and model

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic conf_word_t random_word();
    conf_word_t  w;
    logic [31:0] r;
    logic [31:0] k;
    k = next_random() % 16;
    r = next_random();
    if (k < 9) begin
      w.ctype = conf_type_e'(k[7:0]);
    end else if (k < 11) begin
      // Types past NET_SWITCH
      w.ctype = conf_type_e'(8'd9 + r[7:0] % 8'd200);
    end else begin
      w.ctype = SET_PE_INSTRUCTION;
    end
    r = next_random();
    if (r[4:0] == 5'd0) begin
      w.pe_id = 16'd4 + {4'h0, r[31:20]};
    end else begin
      w.pe_id = {14'h0, r[9:8]};
    end
    w.data   = next_random();
    r        = next_random();
    w.addr   = r[3:0];
    w.thread = r[7:4];
    return w;
  endfunction

  function automatic rb_req_t random_req();
    rb_req_t     r;
    logic [31:0] x;
    x       = next_random();
    r.pe    = x[PE_AW-1:0];
    r.field = rb_field_e'(4'(x[15:8] % 8'd9));
    r.index = x[23:16];
    return r;
  endfunction

  function automatic void apply_word(conf_word_t w);
    logic [PE_AW-1:0] pe;
    pe = w.pe_id[PE_AW-1:0];
    if (w.pe_id < 16'(NUM_PE)) begin
      case (w.ctype)
        SET_PE_INSTRUCTION: begin
          m_inst[pe][w.data[7:0]] = w.data[31:16];
          m_thread[pe]            = w.thread[2:0];
        end
        SET_PE_CONST:        m_const[pe][w.addr] = w.data[15:0];
        SET_PE_PC_MAX:       m_pc_max[pe]        = w.data[7:0];
        SET_PE_PC_LOOP:      m_pc_loop[pe]       = w.data[7:0];
        SET_PE_STORE_IGNORE: m_ignore[pe]        = w.data[7:0];
        default: ;
      endcase
    end
    // Network words ignore pe_id
    case (w.ctype)
      SET_NET_PC_MAX:  m_net_pc_max  = w.data[7:0];
      SET_NET_PC_LOOP: m_net_pc_loop = w.data[7:0];
      NET_SWITCH:      m_sw[w.addr]  = w.data[15:0];
      default: ;
    endcase
  endfunction

  function automatic logic [RB_DW-1:0] expected_value(rb_req_t r);
    case (r.field)
      F_INST:        return m_inst[r.pe][r.index];
      F_CONST:       return m_const[r.pe][r.index[CONST_AW-1:0]];
      F_PC_MAX:      return {8'h00, m_pc_max[r.pe]};
      F_PC_LOOP:     return {8'h00, m_pc_loop[r.pe]};
      F_IGNORE:      return {8'h00, m_ignore[r.pe]};
      F_THREAD:      return {13'h0000, m_thread[r.pe]};
      F_NET_PC_MAX:  return {8'h00, m_net_pc_max};
      F_NET_PC_LOOP: return {8'h00, m_net_pc_loop};
      F_SWITCH:      return m_sw[r.index[SW_AW-1:0]];
      default:       return '0;
    endcase
  endfunction

  // ################################################
  // Host driver

  task automatic send_word(conf_word_t w);
    int   cnt;
    logic accepted;
    if (timed_out) return;
    conf_valid = 1'b1;
    conf_word  = w;
    cnt        = 0;
    accepted   = 1'b0;
    while (!accepted && cnt < TIMEOUT) begin
      @(posedge clk);
      accepted = conf_ready;
      cnt++;
    end
    if (accepted) begin
      apply_word(w);
    end else begin
      $display("Timeout: configuration word not accepted after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      tb_errors++;
    end
    #1;
    conf_valid = 1'b0;
  endtask

  task automatic read_check(rb_req_t r);
    int          cnt;
    logic        done;
    logic [31:0] x;
    if (timed_out) return;
    rb_valid = 1'b1;
    rb_req   = r;
    rb_exp   = expected_value(r);
    cnt      = 0;
    done     = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk);
      done = rb_ready;
      cnt++;
    end
    #1;
    rb_valid = 1'b0;
    if (!done) begin
      $display("Timeout: readback request not accepted after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      tb_errors++;
      return;
    end
    reads_issued++;
    cnt  = 0;
    done = 1'b0;
    // Random stalls on the response side
    while (!done && cnt < TIMEOUT) begin
      x         = next_random();
      rsp_ready = x[0];
      @(posedge clk);
      done = rsp_valid && rsp_ready;
      cnt++;
      #1;
    end
    rsp_ready = 1'b0;
    if (!done) begin
      $display("Timeout: no readback response after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      tb_errors++;
    end
  endtask

  // ################################################
  // Test sequence

  initial begin
    conf_word_t w;
    rb_req_t    r;
    int         n;
    rng_state     = 32'ha866_68a6;
    timed_out     = 1'b0;
    reads_issued  = 0;
    tb_errors     = 0;
    rst           = 1'b1;
    conf_valid    = 1'b0;
    conf_word     = '0;
    rb_valid      = 1'b0;
    rb_req        = '0;
    rsp_ready     = 1'b0;
    rb_exp        = '0;
    m_inst        = '{default: '0};
    m_const       = '{default: '0};
    m_pc_max      = '{default: '0};
    m_pc_loop     = '{default: '0};
    m_ignore      = '{default: '0};
    m_thread      = '{default: '0};
    m_sw          = '{default: '0};
    m_net_pc_max  = '0;
    m_net_pc_loop = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Registers come out of reset as zero
    r.index = '0;
    for (int pe = 0; pe < NUM_PE; pe++) begin
      r.pe    = PE_AW'(pe);
      r.field = F_THREAD;
      read_check(r);
      r.field = F_PC_MAX;
      read_check(r);
    end

    // Instruction memory is not reset, so give it known contents first
    for (int pe = 0; pe < NUM_PE; pe++) begin
      for (int a = 0; a < INST_DEPTH; a++) begin
        w           = random_word();
        w.ctype     = SET_PE_INSTRUCTION;
        w.pe_id     = 16'(pe);
        w.data[7:0] = 8'(a);
        send_word(w);
      end
    end

    // Bursts with reads straight after them
    repeat (NUM_ROUNDS) begin
      n = 1 + int'(next_random() % 6);
      repeat (n) send_word(random_word());
      n = 1 + int'(next_random() % 3);
      repeat (n) read_check(random_req());
    end

    // Sweep of every PE register and constant, plus the network side
    for (int pe = 0; pe < NUM_PE; pe++) begin
      r.pe = PE_AW'(pe);
      for (int i = 0; i < CONST_DEPTH; i++) begin
        r.field = F_CONST;
        r.index = 8'(i);
        read_check(r);
        r.field = F_INST;
        r.index = 8'(i * 16 + pe);
        read_check(r);
      end
      for (int f = int'(F_PC_MAX); f <= int'(F_THREAD); f++) begin
        r.field = rb_field_e'(4'(f));
        read_check(r);
      end
    end
    r.field = F_SWITCH;
    for (int i = 0; i < SW_DEPTH; i++) begin
      r.index = 8'(i);
      read_check(r);
    end
    r.field = F_NET_PC_MAX;
    read_check(r);
    r.field = F_NET_PC_LOOP;
    read_check(r);

    repeat (4) @(posedge clk);
    if (!timed_out && rsp_count != reads_issued) begin
      $display("Lost responses: %0d requests accepted but %0d responses seen",
               reads_issued, rsp_count);
      tb_errors++;
    end
    $display("Reads checked: %0d, checker errors: %0d, testbench errors: %0d",
             rsp_count, err_count, tb_errors);
    if (err_count == 0 && tb_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tests/cgra_conf_checker.sv
module cgra_conf_checker
  import cgra_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             conf_valid,
  input  logic             conf_ready,
  input  logic             rb_valid,
  input  logic             rb_ready,
  input  rb_req_t          rb_req,
  input  logic [RB_DW-1:0] rb_exp,
  input  logic             rsp_valid,
  input  logic             rsp_ready,
  input  logic [RB_DW-1:0] rsp_data,
  output int               err_count,
  output int               rsp_count
);

  rb_req_t          req_q [$];
  logic [RB_DW-1:0] exp_q [$];
  logic             stalled;
  logic [RB_DW-1:0] stalled_data;
  int               land_wait;

  initial begin
    err_count = 0;
    rsp_count = 0;
  end

  always @(posedge clk) begin
    rb_req_t          req;
    logic [RB_DW-1:0] exp_val;
    if (rst) begin
      stalled   <= 1'b0;
      land_wait <= 0;
    end else begin
      if (!conf_ready) begin
        $display("FAILED t=%0t: conf_ready is low outside reset", $time);
        err_count++;
      end

      // A read may only start once every accepted word has reached its store
      if (rb_ready && ((conf_valid && conf_ready) || land_wait != 0 || exp_q.size() != 0)) begin
        $display("FAILED t=%0t: rb_ready high while configuration or a read is in flight",
                 $time);
        err_count++;
      end
      if (conf_valid && conf_ready) begin
        land_wait <= CONF_LAT - 1;
      end else if (land_wait != 0) begin
        land_wait <= land_wait - 1;
      end

      // Expected value was taken from the model when the request was issued
      if (rb_valid && rb_ready) begin
        req_q.push_back(rb_req);
        exp_q.push_back(rb_exp);
      end

      // A stalled response has to stay put
      if (stalled && (!rsp_valid || rsp_data !== stalled_data)) begin
        $display("FAILED t=%0t: response changed under back-pressure, %h became %h",
                 $time, stalled_data, rsp_data);
        err_count++;
      end

      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: a response arrived while no request was outstanding");
          err_count++;
        end else begin
          req     = req_q.pop_front();
          exp_val = exp_q.pop_front();
          rsp_count++;
          if (rsp_data !== exp_val) begin
            $display("FAILED t=%0t: pe %0d field %0d index %0d read %h, expected %h",
                     $time, req.pe, req.field, req.index, rsp_data, exp_val);
            err_count++;
          end
        end
      end

      stalled      <= rsp_valid && !rsp_ready;
      stalled_data <= rsp_data;
    end
  end

endmodule

//--- rtl/cgra_conf_top.sv
module cgra_conf_top
  import cgra_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             conf_valid,
  input  conf_word_t       conf_word,
  output logic             conf_ready,
  input  logic             rb_valid,
  input  rb_req_t          rb_req,
  output logic             rb_ready,
  output logic             rsp_valid,
  input  logic             rsp_ready,
  output logic [RB_DW-1:0] rsp_data
);

  conf_word_t                  bus_word;
  logic                        conf_busy;
  pe_wr_t                      pe_wr [NUM_PE];
  rb_field_e                   sel_field;
  logic [INST_AW-1:0]          sel_index;
  logic [NUM_PE-1:0][RB_DW-1:0] pe_data;
  logic [RB_DW-1:0]            net_data;

  cgra_conf_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .conf_valid (conf_valid),
    .conf_word  (conf_word),
    .conf_ready (conf_ready),
    .bus_word   (bus_word),
    .conf_busy  (conf_busy)
  );

  // ################################################
  // One reader and store per PE

  for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
    cgra_conf_reader_pe #(.PE_ID(i)) u_reader (
      .clk      (clk),
      .rst      (rst),
      .bus_word (bus_word),
      .wr       (pe_wr[i])
    );

    cgra_pe_conf_store u_store (
      .clk      (clk),
      .rst      (rst),
      .wr       (pe_wr[i]),
      .rd_field (sel_field),
      .rd_index (sel_index),
      .rd_data  (pe_data[i])
    );
  end

  cgra_net_conf_reader u_net (
    .clk      (clk),
    .rst      (rst),
    .bus_word (bus_word),
    .rd_field (sel_field),
    .rd_index (sel_index),
    .rd_data  (net_data)
  );

  cgra_conf_readback u_readback (
    .clk       (clk),
    .rst       (rst),
    .conf_busy (conf_busy),
    .rb_valid  (rb_valid),
    .rb_req    (rb_req),
    .rb_ready  (rb_ready),
    .sel_field (sel_field),
    .sel_index (sel_index),
    .pe_data   (pe_data),
    .net_data  (net_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

endmodule

//--- rtl/cgra_conf_readback.sv
module cgra_conf_readback
  import cgra_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       conf_busy,
  input  logic                       rb_valid,
  input  rb_req_t                    rb_req,
  output logic                       rb_ready,
  output rb_field_e                  sel_field,
  output logic [INST_AW-1:0]         sel_index,
  input  logic [NUM_PE-1:0][RB_DW-1:0] pe_data,
  input  logic [RB_DW-1:0]           net_data,
  output logic                       rsp_valid,
  input  logic                       rsp_ready,
  output logic [RB_DW-1:0]           rsp_data
);

  typedef enum logic [1:0] {
    RB_IDLE,
    RB_READ,
    RB_RESP
  } rb_state_e;

  rb_state_e        state;
  rb_req_t          req_q;
  logic             is_net;
  logic [RB_DW-1:0] sel_data;

  // Hold off reads while words are still moving to the stores
  assign rb_ready  = (state == RB_IDLE) && !conf_busy;
  assign rsp_valid = (state == RB_RESP);

  assign sel_field = req_q.field;
  assign sel_index = req_q.index;
  assign is_net    = req_q.field inside {F_NET_PC_MAX, F_NET_PC_LOOP, F_SWITCH};
  assign sel_data  = is_net ? net_data : pe_data[req_q.pe];

  // ################################################
  // Request / response FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RB_IDLE;
    end else begin
      case (state)
        RB_IDLE: begin
          if (rb_valid && rb_ready) begin
            state <= RB_READ;
          end
        end
        RB_READ: state <= RB_RESP;
        RB_RESP: begin
          if (rsp_ready) begin
            state <= RB_IDLE;
          end
        end
        default: state <= RB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rb_valid && rb_ready) begin
      req_q <= rb_req;
    end
  end

  // Response only loads in RB_READ so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (state == RB_READ) begin
      rsp_data <= sel_data;
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

//--- rtl/cgra_net_conf_reader.sv
module cgra_net_conf_reader
  import cgra_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  conf_word_t         bus_word,
  input  rb_field_e          rd_field,
  input  logic [INST_AW-1:0] rd_index,
  output logic [RB_DW-1:0]   rd_data
);

  conf_word_t       s1_word;
  logic             pc_max_we;
  logic             pc_loop_we;
  logic             sw_we;
  logic [7:0]       value8;
  logic [SW_AW-1:0] sw_addr;
  logic [15:0]      sw_data;
  logic [7:0]       net_pc_max;
  logic [7:0]       net_pc_loop;
  logic [15:0]      sw_table [SW_DEPTH];

  // Stage 1, pe_id is not looked at
  always_ff @(posedge clk) begin
    s1_word <= bus_word;
  end

  // Stage 2
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_max_we  <= 1'b0;
      pc_loop_we <= 1'b0;
      sw_we      <= 1'b0;
    end else begin
      pc_max_we  <= (s1_word.ctype == SET_NET_PC_MAX);
      pc_loop_we <= (s1_word.ctype == SET_NET_PC_LOOP);
      sw_we      <= (s1_word.ctype == NET_SWITCH);
    end
    value8  <= s1_word.data[7:0];
    sw_addr <= s1_word.addr[SW_AW-1:0];
    sw_data <= s1_word.data[15:0];
  end

  // Store, same depth as a PE store
  always_ff @(posedge clk) begin
    if (rst) begin
      net_pc_max  <= '0;
      net_pc_loop <= '0;
      for (int i = 0; i < SW_DEPTH; i++) begin
        sw_table[i] <= '0;
      end
    end else begin
      if (pc_max_we) begin
        net_pc_max <= value8;
      end
      if (pc_loop_we) begin
        net_pc_loop <= value8;
      end
      if (sw_we) begin
        sw_table[sw_addr] <= sw_data;
      end
    end
  end

  always_comb begin
    case (rd_field)
      F_NET_PC_MAX:  rd_data = RB_DW'(net_pc_max);
      F_NET_PC_LOOP: rd_data = RB_DW'(net_pc_loop);
      F_SWITCH:      rd_data = RB_DW'(sw_table[rd_index[SW_AW-1:0]]);
      default:       rd_data = '0;
    endcase
  end

endmodule

//--- rtl/cgra_pe_conf_store.sv
module cgra_pe_conf_store
  import cgra_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  pe_wr_t             wr,
  input  rb_field_e          rd_field,
  input  logic [INST_AW-1:0] rd_index,
  output logic [RB_DW-1:0]   rd_data
);

  logic [INST_W-1:0] inst_mem [INST_DEPTH];
  logic [15:0]       const_mem [CONST_DEPTH];
  logic [7:0]        pc_max;
  logic [7:0]        pc_loop;
  logic [7:0]        ignore_val;
  logic [2:0]        thread;

  // ################################################
  // Write side

  always_ff @(posedge clk) begin
    if (wr.inst_we) begin
      inst_mem[wr.inst_addr] <= wr.inst_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CONST_DEPTH; i++) begin
        const_mem[i] <= '0;
      end
      pc_max     <= '0;
      pc_loop    <= '0;
      ignore_val <= '0;
      thread     <= '0;
    end else begin
      if (wr.const_we) begin
        const_mem[wr.const_addr] <= wr.const_data;
      end
      if (wr.pc_max_we) begin
        pc_max <= wr.value8;
      end
      if (wr.pc_loop_we) begin
        pc_loop <= wr.value8;
      end
      if (wr.ignore_we) begin
        ignore_val <= wr.value8;
      end
      // Thread follows the latest instruction
      if (wr.inst_we) begin
        thread <= wr.thread;
      end
    end
  end

  // ################################################
  // Read side

  always_comb begin
    case (rd_field)
      F_INST:    rd_data = RB_DW'(inst_mem[rd_index]);
      F_CONST:   rd_data = RB_DW'(const_mem[rd_index[CONST_AW-1:0]]);
      F_PC_MAX:  rd_data = RB_DW'(pc_max);
      F_PC_LOOP: rd_data = RB_DW'(pc_loop);
      F_IGNORE:  rd_data = RB_DW'(ignore_val);
      F_THREAD:  rd_data = RB_DW'(thread);
      default:   rd_data = '0;
    endcase
  end

endmodule

//--- rtl/cgra_conf_reader_pe.sv
module cgra_conf_reader_pe
  import cgra_pkg::*;
#(
  parameter int PE_ID = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  conf_word_t bus_word,
  output pe_wr_t     wr
);

  conf_word_t s1_word;
  logic       s1_hit;
  pe_wr_t     wr_d;

  // ################################################
  // Stage 1: capture the bus word and match the PE

  always_ff @(posedge clk) begin
    s1_word <= bus_word;
    s1_hit  <= (bus_word.pe_id == 16'(PE_ID));
  end

  // ################################################
  // Stage 2: type decode and field reformat

  always_comb begin
    wr_d            = '0;
    wr_d.inst_addr  = s1_word.data[INST_AW-1:0];
    wr_d.inst_data  = s1_word.data[31:16];
    wr_d.const_addr = s1_word.addr[CONST_AW-1:0];
    wr_d.const_data = s1_word.data[15:0];
    wr_d.value8     = s1_word.data[7:0];
    wr_d.thread     = s1_word.thread[2:0];
    if (s1_hit) begin
      case (s1_word.ctype)
        SET_PE_INSTRUCTION:  wr_d.inst_we    = 1'b1;
        SET_PE_CONST:        wr_d.const_we   = 1'b1;
        SET_PE_PC_MAX:       wr_d.pc_max_we  = 1'b1;
        SET_PE_PC_LOOP:      wr_d.pc_loop_we = 1'b1;
        SET_PE_STORE_IGNORE: wr_d.ignore_we  = 1'b1;
        // network and unknown types are handled elsewhere
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr.inst_we    <= 1'b0;
      wr.const_we   <= 1'b0;
      wr.pc_max_we  <= 1'b0;
      wr.pc_loop_we <= 1'b0;
      wr.ignore_we  <= 1'b0;
    end else begin
      wr <= wr_d;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({wr.inst_we, wr.const_we, wr.pc_max_we, wr.pc_loop_we, wr.ignore_we}));

endmodule

//--- rtl/cgra_conf_loader.sv
module cgra_conf_loader
  import cgra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       conf_valid,
  input  conf_word_t conf_word,
  output logic       conf_ready,
  output conf_word_t bus_word,
  output logic       conf_busy
);

  logic                  accept;
  logic [CONF_CNT_W-1:0] busy_cnt;

  assign accept = conf_valid && conf_ready;

  // The bus never stalls, so ready only drops in reset
  assign conf_ready = !rst;

  // Idle cycles keep the payload but mark the word as NOT_CONF
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_word <= '0;
    end else if (accept) begin
      bus_word <= conf_word;
    end else begin
      bus_word.ctype <= NOT_CONF;
    end
  end

  // Busy until the last accepted word has landed in its store
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_cnt <= '0;
    end else if (accept) begin
      busy_cnt <= CONF_CNT_W'(CONF_LAT);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign conf_busy = accept || (busy_cnt != '0);

  a_idle_not_conf: assert property (@(posedge clk) disable iff (rst)
    !accept |=> bus_word.ctype == NOT_CONF);

endmodule

//--- rtl/cgra_pkg.sv
package cgra_pkg;

  // ################################################
  // Array sizes

  localparam int NUM_PE      = 4;
  localparam int PE_AW       = $clog2(NUM_PE);
  localparam int INST_DEPTH  = 256;
  localparam int INST_AW     = $clog2(INST_DEPTH);
  localparam int INST_W      = 16;
  localparam int CONST_DEPTH = 16;
  localparam int CONST_AW    = $clog2(CONST_DEPTH);
  localparam int SW_DEPTH    = 16;
  localparam int SW_AW       = $clog2(SW_DEPTH);
  localparam int RB_DW       = 16;

  // Accept to store write, also the busy window
  localparam int CONF_LAT    = 4;
  localparam int CONF_CNT_W  = $clog2(CONF_LAT + 1);

  // ################################################
  // Configuration word

  typedef enum logic [7:0] {
    NOT_CONF            = 8'd0,
    SET_PE_INSTRUCTION  = 8'd1,
    SET_PE_CONST        = 8'd2,
    SET_PE_PC_MAX       = 8'd3,
    SET_PE_PC_LOOP      = 8'd4,
    SET_PE_STORE_IGNORE = 8'd5,
    SET_NET_PC_MAX      = 8'd6,
    SET_NET_PC_LOOP     = 8'd7,
    NET_SWITCH          = 8'd8
  } conf_type_e;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  addr;
    logic [3:0]  thread;
    logic [15:0] pe_id;
    conf_type_e  ctype;
  } conf_word_t;

  // ################################################
  // Readback

  typedef enum logic [3:0] {
    F_INST,
    F_CONST,
    F_PC_MAX,
    F_PC_LOOP,
    F_IGNORE,
    F_THREAD,
    F_NET_PC_MAX,
    F_NET_PC_LOOP,
    F_SWITCH
  } rb_field_e;

  typedef struct packed {
    logic [PE_AW-1:0]   pe;
    rb_field_e          field;
    logic [INST_AW-1:0] index;
  } rb_req_t;

  // Reader to store write port
  typedef struct packed {
    logic                inst_we;
    logic [INST_AW-1:0]  inst_addr;
    logic [INST_W-1:0]   inst_data;
    logic                const_we;
    logic [CONST_AW-1:0] const_addr;
    logic [15:0]         const_data;
    logic                pc_max_we;
    logic                pc_loop_we;
    logic                ignore_we;
    logic [7:0]          value8;
    logic [2:0]          thread;
  } pe_wr_t;

endpackage
